/* list.f */
verilog/codes.sv
verilog/cpu_pc.sv
verilog/cpu_control.sv
verilog/cpu_decode.sv
verilog/cpu_regfile.sv
verilog/cpu_execute.sv
verilog/cpu_result.sv
verilog/cpu_top.sv
tb/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# The simulator is rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the pass message appears in the output.
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* tb/cpu_tb.sv */
`timescale 1ns/100ps

module cpu_tb;

  localparam codes::size_t reset_vector = 32'hbfc00000;
  // The longest directed program in words sets the cycle budget of one run.
  localparam int longest_program = 13;
  localparam int cycle_limit = 3 * longest_program + 50;

  logic         clk;
  logic         reset;
  codes::size_t instr_address;
  logic         instr_read;
  codes::size_t instr_readdata;
  codes::size_t data_address;
  logic         data_read;
  logic         data_write;
  codes::size_t data_writedata;
  codes::size_t data_readdata;
  logic         active;
  codes::size_t register_v0;

  codes::size_t imem [64];
  codes::size_t dmem [256];
  codes::size_t instr_offset;
  codes::size_t prog [$];
  int           seed;
  int           run_cycles = 0;
  int           fetch_count = 0;
  int           read_count = 0;
  int           write_count = 0;
  int           error_count = 0;
  int           test_errors = 0;
  int           tests_run = 0;
  int           tests_failed = 0;

  cpu_top #(.reset_vector(reset_vector)) cpu_top_inst (
    .clk(clk), .reset(reset), .instr_address(instr_address), .instr_read(instr_read),
    .instr_readdata(instr_readdata), .data_address(data_address), .data_read(data_read),
    .data_write(data_write), .data_writedata(data_writedata),
    .data_readdata(data_readdata), .active(active), .register_v0(register_v0)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Programs sit at the reset vector. Words outside the program read as nop.
  assign instr_offset   = instr_address - reset_vector;
  assign instr_readdata = (instr_offset < 32'd256) ? imem[instr_offset[7:2]] : '0;
  // Data memory covers a 1 KiB window and answers in the same cycle.
  assign data_readdata  = dmem[data_address[9:2]];

  // Each reset refills data memory with a pattern built from the byte address.
  // Stores land on the edge that ends exec1.
  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 256; i++) begin
        dmem[8'(i)] <= 32'ha5a50000 ^ (i << 2);
      end
    end else if (data_write) begin
      dmem[data_address[9:2]] <= data_writedata;
    end
    if (instr_read) begin
      fetch_count <= fetch_count + 1;
    end
    // Every cycle with a data strobe high is one memory access.
    if (data_read) begin
      read_count <= read_count + 1;
    end
    if (data_write) begin
      write_count <= write_count + 1;
    end
  end

  // A run that never halts ends the simulation here.
  initial begin
    wait (run_cycles > cycle_limit);
    $display("Timeout: the CPU did not halt within %0d cycles", cycle_limit);
    $display("Simulation finished: FAIL");
    $finish;
  end

  task automatic check_word(input string name, input codes::size_t expected,
                            input codes::size_t actual);
    if (actual !== expected) begin
      $display("Error at %0d ns: %s expected %h, actual %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Error at %0d ns: %s expected %b, actual %b", $time, name, expected, actual);
      error_count++;
    end
  endtask

  // Instruction encoders, written in assembler operand order.
  function automatic codes::size_t r_type(input logic [5:0] funct, input codes::reg_idx_t rd,
                                          input codes::reg_idx_t rs, input codes::reg_idx_t rt,
                                          input logic [4:0] shamt);
    return {codes::primary_special, rs, rt, rd, shamt, funct};
  endfunction

  function automatic codes::size_t i_type(input logic [5:0] primary, input codes::reg_idx_t rt,
                                          input codes::reg_idx_t rs, input logic [15:0] imm);
    return {primary, rs, rt, imm};
  endfunction

  // jr $0 with a nop in its delay slot.
  task automatic emit_halt();
    prog.push_back(r_type(codes::funct_jr, 5'd0, 5'd0, 5'd0, 5'd0));
    prog.push_back(32'h00000000);
  endtask

  // Copies the built program into instruction memory and resets the CPU for 4 cycles.
  task automatic start_program();
    if (prog.size() > longest_program) begin
      $display("Program of %0d words is longer than the timeout allows", prog.size());
      error_count++;
    end
    for (int i = 0; i < 64; i++) begin
      imem[6'(i)] = (i < prog.size()) ? prog[i] : '0;
    end
    prog.delete();
    @(posedge clk);
    #2 reset = 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_bit("instr_read", 1'b0, instr_read);
      @(posedge clk);
    end
    #2 reset = 1'b0;
    run_cycles = 0;
  endtask

  // Outputs are sampled at the falling edge, away from the DUT's updates.
  task automatic wait_cycle();
    @(negedge clk);
    run_cycles++;
  endtask

  task automatic run_to_halt();
    while (active === 1'b1) begin
      wait_cycle();
    end
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (error_count == test_errors) begin
      $display("Test %s passed", name);
    end else begin
      $display("Test %s failed with %0d errors", name, error_count - test_errors);
      tests_failed++;
    end
    test_errors = error_count;
  endtask

  task automatic reset_and_fetch();
    prog.push_back(i_type(codes::primary_addiu, 5'd2, 5'd0, 16'h1234));
    emit_halt();
    start_program();
    while (instr_read !== 1'b1) begin
      wait_cycle();
    end
    check_word("instr_address", reset_vector, instr_address);
    check_bit("active", 1'b1, active);
    run_to_halt();
    check_word("register_v0", 32'h00001234, register_v0);
    close_test("reset");
  endtask

  task automatic alu_chain();
    codes::size_t r8;
    codes::size_t r9;
    codes::size_t r10;
    codes::size_t r11;
    codes::size_t r14;
    codes::size_t r15;
    codes::size_t r16;
    // Reference values follow the MIPS definitions step by step.
    r8  = 32'hfffffffd;
    r9  = 32'h12340000 | 32'h00005678;
    r10 = r8 + r9;
    r11 = r9 - r8;
    r14 = (r10 & r11) ^ (r10 | r11);
    // The compare treats both words as two's complement numbers.
    r15 = ($signed(r8) < $signed(r9)) ? 32'd1 : 32'd0;
    r16 = r14 << 4;
    prog.push_back(i_type(codes::primary_addiu, 5'd8, 5'd0, 16'hfffd));
    prog.push_back(i_type(codes::primary_lui, 5'd9, 5'd0, 16'h1234));
    prog.push_back(i_type(codes::primary_ori, 5'd9, 5'd9, 16'h5678));
    prog.push_back(r_type(codes::funct_addu, 5'd10, 5'd8, 5'd9, 5'd0));
    prog.push_back(r_type(codes::funct_subu, 5'd11, 5'd9, 5'd8, 5'd0));
    prog.push_back(r_type(codes::funct_and, 5'd12, 5'd10, 5'd11, 5'd0));
    prog.push_back(r_type(codes::funct_or, 5'd13, 5'd10, 5'd11, 5'd0));
    prog.push_back(r_type(codes::funct_xor, 5'd14, 5'd12, 5'd13, 5'd0));
    prog.push_back(r_type(codes::funct_slt, 5'd15, 5'd8, 5'd9, 5'd0));
    prog.push_back(r_type(codes::funct_sll, 5'd16, 5'd0, 5'd14, 5'd4));
    prog.push_back(r_type(codes::funct_addu, 5'd2, 5'd16, 5'd15, 5'd0));
    emit_halt();
    start_program();
    run_to_halt();
    check_word("register_v0", r16 + r15, register_v0);
    close_test("alu");
  endtask

  task automatic store_then_load();
    int reads;
    int writes;
    prog.push_back(i_type(codes::primary_lui, 5'd8, 5'd0, 16'hdead));
    prog.push_back(i_type(codes::primary_ori, 5'd8, 5'd8, 16'hbeef));
    prog.push_back(i_type(codes::primary_addiu, 5'd9, 5'd0, 16'h0040));
    prog.push_back(i_type(codes::primary_sw, 5'd8, 5'd9, 16'h0008));
    prog.push_back(i_type(codes::primary_lw, 5'd2, 5'd9, 16'h0008));
    emit_halt();
    start_program();
    reads  = read_count;
    writes = write_count;
    run_to_halt();
    check_word("register_v0", 32'hdeadbeef, register_v0);
    // Base 0x40 plus offset 8 is byte 0x48, which is word 18.
    check_word("dmem[0x48]", 32'hdeadbeef, dmem[18]);
    // The one lw and the one sw each hold their strobe for a single exec1 cycle.
    check_word("data_read cycles", 32'd1, codes::size_t'(read_count - reads));
    check_word("data_write cycles", 32'd1, codes::size_t'(write_count - writes));
    close_test("memory");
  endtask

  task automatic branch_delay_slots();
    prog.push_back(i_type(codes::primary_addiu, 5'd8, 5'd0, 16'h0005));
    prog.push_back(i_type(codes::primary_addiu, 5'd9, 5'd0, 16'h0005));
    // The beq is taken and lands two words past the delay slot.
    prog.push_back(i_type(codes::primary_beq, 5'd9, 5'd8, 16'h0002));
    prog.push_back(i_type(codes::primary_addiu, 5'd2, 5'd2, 16'h0001));
    prog.push_back(i_type(codes::primary_addiu, 5'd2, 5'd2, 16'h0100));
    // The bne is not taken, so execution falls through after the slot.
    prog.push_back(i_type(codes::primary_bne, 5'd9, 5'd8, 16'h0005));
    prog.push_back(i_type(codes::primary_addiu, 5'd2, 5'd2, 16'h0010));
    prog.push_back(i_type(codes::primary_addiu, 5'd2, 5'd2, 16'h0020));
    emit_halt();
    start_program();
    run_to_halt();
    // Both slots and the fall-through add in, the skipped 0x100 does not.
    check_word("register_v0", 32'h1 + 32'h10 + 32'h20, register_v0);
    close_test("branch");
  endtask

  task automatic halt_on_jump_zero();
    int fetches;
    prog.push_back(i_type(codes::primary_addiu, 5'd2, 5'd0, 16'h0007));
    prog.push_back(r_type(codes::funct_jr, 5'd0, 5'd4, 5'd0, 5'd0));
    prog.push_back(i_type(codes::primary_addiu, 5'd2, 5'd2, 16'h0001));
    prog.push_back(i_type(codes::primary_addiu, 5'd2, 5'd2, 16'h0040));
    start_program();
    run_to_halt();
    fetches = fetch_count;
    check_bit("active", 1'b0, active);
    repeat (10) begin
      wait_cycle();
    end
    check_word("fetch_count", codes::size_t'(fetches), codes::size_t'(fetch_count));
    check_word("register_v0", 32'h00000008, register_v0);
    close_test("halt");
  endtask

  // Loads both operands with lui and ori, then runs one R-type into v0.
  task automatic random_case(input logic [5:0] funct, input codes::size_t a,
                             input codes::size_t b, input codes::size_t expected);
    prog.push_back(i_type(codes::primary_lui, 5'd8, 5'd0, a[31:16]));
    prog.push_back(i_type(codes::primary_ori, 5'd8, 5'd8, a[15:0]));
    prog.push_back(i_type(codes::primary_lui, 5'd9, 5'd0, b[31:16]));
    prog.push_back(i_type(codes::primary_ori, 5'd9, 5'd9, b[15:0]));
    prog.push_back(r_type(funct, 5'd2, 5'd8, 5'd9, 5'd0));
    emit_halt();
    start_program();
    run_to_halt();
    check_word("register_v0", expected, register_v0);
  endtask

  task automatic seeded_alu_ops();
    codes::size_t a;
    codes::size_t b;
    for (int n = 0; n < 3; n++) begin
      a = $random(seed);
      b = $random(seed);
      random_case(codes::funct_addu, a, b, a + b);
      random_case(codes::funct_subu, a, b, a - b);
      random_case(codes::funct_xor, a, b, a ^ b);
      random_case(codes::funct_slt, a, b, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    end
    close_test("random");
  endtask

  initial begin
    reset = 1'b1;
    seed  = 32'h4a901628;
    reset_and_fetch();
    alu_chain();
    store_then_load();
    branch_delay_slots();
    halt_on_jump_zero();
    seeded_alu_ops();
    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* verilog/cpu_top.sv */
`timescale 1ns/100ps

module cpu_top #(
  parameter codes::size_t reset_vector = 32'hbfc00000
) (
  input  logic         clk,
  input  logic         reset,
  // Instruction memory side.
  output codes::size_t instr_address,
  output logic         instr_read,
  input  codes::size_t instr_readdata,
  // Data memory side.
  output codes::size_t data_address,
  output logic         data_read,
  output logic         data_write,
  output codes::size_t data_writedata,
  input  codes::size_t data_readdata,
  // Status.
  output logic         active,
  output codes::size_t register_v0
);

  codes::state_t   state;
  logic            ir_load;
  logic            pc_wen;
  codes::size_t    pc;
  codes::opcode_t  opcode;
  codes::reg_idx_t rs;
  codes::reg_idx_t rt;
  codes::reg_idx_t rd;
  logic [4:0]      shamt;
  codes::size_t    imm;
  codes::size_t    read_a;
  codes::size_t    read_b;
  codes::size_t    alu_out;
  logic            b_cond_met;
  codes::size_t    branch_target;
  codes::size_t    load_data;
  logic            jump_zero;
  logic            write_enable;
  codes::reg_idx_t write_index;
  codes::size_t    write_data;

  // The counter addresses instruction memory directly.
  assign instr_address = pc;
  assign instr_read    = ir_load;
  // Stores always take their data from the rt register.
  assign data_writedata = read_b;

  cpu_pc #(.reset_vector(reset_vector)) pc_inst (
    .clk(clk), .reset(reset), .wen(pc_wen), .b_cond_met(b_cond_met),
    .pc_i(branch_target), .pc_o(pc)
  );

  cpu_control control_inst (
    .clk(clk), .reset(reset), .jump_zero(jump_zero), .state(state),
    .ir_load(ir_load), .pc_wen(pc_wen), .active(active)
  );

  cpu_decode decode_inst (
    .clk(clk), .reset(reset), .ir_load(ir_load), .instr_readdata(instr_readdata),
    .opcode(opcode), .rs(rs), .rt(rt), .rd(rd), .shamt(shamt), .imm(imm)
  );

  cpu_regfile regfile_inst (
    .clk(clk), .reset(reset), .rs(rs), .rt(rt), .write_enable(write_enable),
    .write_index(write_index), .write_data(write_data), .read_a(read_a),
    .read_b(read_b), .register_v0(register_v0)
  );

  cpu_execute execute_inst (
    .clk(clk), .reset(reset), .state(state), .opcode(opcode), .read_a(read_a),
    .read_b(read_b), .imm(imm), .shamt(shamt), .pc(pc), .data_readdata(data_readdata),
    .alu_out(alu_out), .b_cond_met(b_cond_met), .branch_target(branch_target),
    .mem_address(data_address), .load_data(load_data), .jump_zero(jump_zero),
    .data_read(data_read), .data_write(data_write)
  );

  cpu_result result_inst (
    .state(state), .opcode(opcode), .rt(rt), .rd(rd), .alu_out(alu_out),
    .load_data(load_data), .write_enable(write_enable), .write_index(write_index),
    .write_data(write_data)
  );

endmodule

/* verilog/cpu_result.sv */
`timescale 1ns/100ps

module cpu_result (
  input  codes::state_t   state,
  input  codes::opcode_t  opcode,
  input  codes::reg_idx_t rt,
  input  codes::reg_idx_t rd,
  input  codes::size_t    alu_out,
  input  codes::size_t    load_data,
  output logic            write_enable,
  output codes::reg_idx_t write_index,
  output codes::size_t    write_data
);

  logic writes_rd;
  logic writes_rt;

  // Register-register forms write rd.
  assign writes_rd = (opcode == codes::op_addu) || (opcode == codes::op_subu) ||
                     (opcode == codes::op_and)  || (opcode == codes::op_or)   ||
                     (opcode == codes::op_xor)  || (opcode == codes::op_slt)  ||
                     (opcode == codes::op_sll);

  // Immediate forms and loads write rt.
  assign writes_rt = (opcode == codes::op_addiu) || (opcode == codes::op_ori) ||
                     (opcode == codes::op_lui)   || (opcode == codes::op_lw);

  // The register file is written on the exec2 edge only.
  assign write_enable = (state == codes::st_exec2) && (writes_rd || writes_rt);
  assign write_index  = writes_rd ? rd : rt;
  assign write_data   = (opcode == codes::op_lw) ? load_data : alu_out;

endmodule

/* verilog/cpu_execute.sv */
`timescale 1ns/100ps

module cpu_execute (
  input  logic           clk,
  input  logic           reset,
  input  codes::state_t  state,
  input  codes::opcode_t opcode,
  input  codes::size_t   read_a,
  input  codes::size_t   read_b,
  input  codes::size_t   imm,
  input  logic [4:0]     shamt,
  input  codes::size_t   pc,
  input  codes::size_t   data_readdata,
  output codes::size_t   alu_out,
  output logic           b_cond_met,
  output codes::size_t   branch_target,
  output codes::size_t   mem_address,
  output codes::size_t   load_data,
  output logic           jump_zero,
  output logic           data_read,
  output logic           data_write
);

  logic taken;
  logic is_exec1;
  logic is_exec2;

  assign is_exec1 = (state == codes::st_exec1);
  assign is_exec2 = (state == codes::st_exec2);

  // Loads and stores address memory with base plus signed offset.
  assign mem_address = read_a + imm;

  always_comb begin
    case (opcode)
      codes::op_addu:  alu_out = read_a + read_b;
      codes::op_subu:  alu_out = read_a - read_b;
      codes::op_and:   alu_out = read_a & read_b;
      codes::op_or:    alu_out = read_a | read_b;
      codes::op_xor:   alu_out = read_a ^ read_b;
      // A signed compare leaves a single bit in the low position.
      codes::op_slt:   alu_out = {31'd0, $signed(read_a) < $signed(read_b)};
      codes::op_sll:   alu_out = read_b << shamt;
      codes::op_addiu: alu_out = read_a + imm;
      codes::op_ori:   alu_out = read_a | imm;
      // The decoder has already placed the immediate in the upper half.
      codes::op_lui:   alu_out = imm;
      default:         alu_out = mem_address;
    endcase
  end

  // The branch decision.
  // A jr is always taken.
  always_comb begin
    case (opcode)
      codes::op_beq: taken = (read_a == read_b);
      codes::op_bne: taken = (read_a != read_b);
      codes::op_jr:  taken = 1'b1;
      default:       taken = 1'b0;
    endcase
  end

  // Branch offsets count words from the delay slot address.
  // A jr goes to the register value instead.
  assign branch_target = (opcode == codes::op_jr) ? read_a : pc + 32'd4 + (imm << 2);

  // Both flags are only valid in exec2, the cycle the counter is written.
  assign b_cond_met = is_exec2 && taken;
  assign jump_zero  = is_exec2 && (opcode == codes::op_jr) && (read_a == '0);

  // Memory strobes are levels for the whole of exec1.
  assign data_read  = is_exec1 && (opcode == codes::op_lw);
  assign data_write = is_exec1 && (opcode == codes::op_sw);

  // Read data arrives in exec1 and is held for the writeback in exec2.
  always_ff @(posedge clk) begin
    if (reset) begin
      load_data <= '0;
    end else if (data_read) begin
      load_data <= data_readdata;
    end
  end

endmodule

/* verilog/cpu_regfile.sv */
`timescale 1ns/100ps

module cpu_regfile (
  input  logic            clk,
  input  logic            reset,
  input  codes::reg_idx_t rs,
  input  codes::reg_idx_t rt,
  input  logic            write_enable,
  input  codes::reg_idx_t write_index,
  input  codes::size_t    write_data,
  output codes::size_t    read_a,
  output codes::size_t    read_b,
  output codes::size_t    register_v0
);

  codes::size_t regs [32];

  // All registers are architecturally zero after reset.
  // Register zero is never written, so it keeps that value for good.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && (write_index != 5'd0)) begin
      regs[write_index] <= write_data;
    end
  end

  // Both read ports are combinational.
  assign read_a = regs[rs];
  assign read_b = regs[rt];

  // v0 is register 2 and is brought out for observation.
  assign register_v0 = regs[2];

endmodule

/* verilog/cpu_decode.sv */
`timescale 1ns/100ps

module cpu_decode (
  input  logic           clk,
  input  logic           reset,
  input  logic           ir_load,
  input  codes::size_t   instr_readdata,
  output codes::opcode_t opcode,
  output codes::reg_idx_t rs,
  output codes::reg_idx_t rt,
  output codes::reg_idx_t rd,
  output logic [4:0]     shamt,
  output codes::size_t   imm
);

  codes::size_t ir;
  logic [5:0]   primary;
  logic [5:0]   funct;

  // The instruction register holds the word for exec1 and exec2.
  // An all-zero word decodes as sll to register zero, which does nothing.
  always_ff @(posedge clk) begin
    if (reset) begin
      ir <= '0;
    end else if (ir_load) begin
      ir <= instr_readdata;
    end
  end

  assign primary = ir[31:26];
  assign funct   = ir[5:0];
  assign rs      = ir[25:21];
  assign rt      = ir[20:16];
  assign rd      = ir[15:11];
  assign shamt   = ir[10:6];

  // Map the MIPS encoding onto the internal operation.
  always_comb begin
    opcode = codes::op_invalid;
    case (primary)
      codes::primary_special: begin
        case (funct)
          codes::funct_sll:  opcode = codes::op_sll;
          codes::funct_jr:   opcode = codes::op_jr;
          codes::funct_addu: opcode = codes::op_addu;
          codes::funct_subu: opcode = codes::op_subu;
          codes::funct_and:  opcode = codes::op_and;
          codes::funct_or:   opcode = codes::op_or;
          codes::funct_xor:  opcode = codes::op_xor;
          codes::funct_slt:  opcode = codes::op_slt;
          default:           opcode = codes::op_invalid;
        endcase
      end
      codes::primary_beq:   opcode = codes::op_beq;
      codes::primary_bne:   opcode = codes::op_bne;
      codes::primary_addiu: opcode = codes::op_addiu;
      codes::primary_ori:   opcode = codes::op_ori;
      codes::primary_lui:   opcode = codes::op_lui;
      codes::primary_lw:    opcode = codes::op_lw;
      codes::primary_sw:    opcode = codes::op_sw;
      default:              opcode = codes::op_invalid;
    endcase
  end

  // Logical immediates are zero extended and lui moves the field to the top half.
  // Arithmetic, memory and branch offsets are sign extended.
  always_comb begin
    case (opcode)
      codes::op_ori: imm = {16'h0000, ir[15:0]};
      codes::op_lui: imm = {ir[15:0], 16'h0000};
      default:       imm = {{16{ir[15]}}, ir[15:0]};
    endcase
  end

endmodule

/* verilog/cpu_control.sv */
`timescale 1ns/100ps

module cpu_control (
  input  logic          clk,
  input  logic          reset,
  input  logic          jump_zero,
  output codes::state_t state,
  output logic          ir_load,
  output logic          pc_wen,
  output logic          active
);

  // Low for one cycle after reset so the counter can load the reset vector first.
  logic primed;
  // Set by a jump to zero. The delay slot still runs before the halt.
  logic pending_halt;

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= codes::st_fetch;
      primed       <= 1'b0;
      pending_halt <= 1'b0;
    end else begin
      primed <= 1'b1;

      if (jump_zero) begin
        pending_halt <= 1'b1;
      end

      case (state)
        // The fetch waits until the counter holds the reset vector.
        codes::st_fetch:  state <= primed ? codes::st_exec1 : codes::st_fetch;
        codes::st_exec1:  state <= codes::st_exec2;
        // The slot after a jump to zero is the last instruction to run.
        codes::st_exec2:  state <= pending_halt ? codes::st_halted : codes::st_fetch;
        default:          state <= codes::st_halted;
      endcase
    end
  end

  // The instruction register loads on the same cycle the memory is read.
  assign ir_load = (state == codes::st_fetch) && primed;
  assign pc_wen  = (state == codes::st_exec2);
  assign active  = (state != codes::st_halted);

endmodule

/* verilog/cpu_pc.sv */
`timescale 1ns/100ps

module cpu_pc #(
  parameter codes::size_t reset_vector = 32'hbfc00000
) (
  input  logic         clk,
  input  logic         reset,
  // Only a rising edge with wen high advances the counter.
  // The sequencer raises it for one state per instruction.
  input  logic         wen,
  // A branch seen here lands on the write after next, which leaves one delay slot.
  input  logic         b_cond_met,
  // Branch or jump destination, sampled together with b_cond_met.
  input  codes::size_t pc_i,
  output codes::size_t pc_o
);

  codes::size_t pc_q;
  codes::size_t branch_q;
  logic         sel_branch_q;
  logic         reset_q;

  assign pc_o = pc_q;

  always_ff @(posedge clk) begin
    // The previous reset level is kept so that its release can be seen.
    reset_q <= reset;

    if (reset) begin
      // While reset is held the counter reads zero and no branch is pending.
      pc_q         <= '0;
      branch_q     <= '0;
      sel_branch_q <= 1'b0;
    end else if (reset_q && !reset) begin
      // Reset has just been released.
      // The first fetch address is loaded here, one cycle after reset falls.
      pc_q <= reset_vector;
    end else if (wen) begin
      // A target captured on the previous write is taken now.
      // Otherwise the counter steps to the next word.
      if (sel_branch_q) begin
        pc_q <= branch_q;
      end else begin
        pc_q <= pc_q + 32'd4;
      end

      // A new target is only recorded when the branch is taken.
      // The old one stays put and is ignored while the select flag is low.
      if (b_cond_met) begin
        branch_q <= pc_i;
      end

      sel_branch_q <= b_cond_met;
    end
  end

endmodule

/* verilog/codes.sv */
package codes;

  // A machine word. Addresses, data and the program counter all use it.
  typedef logic [31:0] size_t;

  // Index into the thirty-two entry register file.
  typedef logic [4:0] reg_idx_t;

  // Internal operations after decode.
  // Anything the decoder does not recognise becomes op_invalid and behaves as a no-op.
  typedef enum logic [3:0] {
    op_addu, op_subu, op_and, op_or, op_xor, op_slt, op_sll,
    op_addiu, op_ori, op_lui,
    op_lw, op_sw,
    op_beq, op_bne, op_jr,
    op_invalid
  } opcode_t;

  // Sequencer states. Every instruction walks fetch, exec1 and exec2.
  typedef enum logic [1:0] {
    st_fetch, st_exec1, st_exec2, st_halted
  } state_t;

  // Primary opcode field, instruction bits 31 to 26.
  localparam logic [5:0] primary_special = 6'h00;
  localparam logic [5:0] primary_beq     = 6'h04;
  localparam logic [5:0] primary_bne     = 6'h05;
  localparam logic [5:0] primary_addiu   = 6'h09;
  localparam logic [5:0] primary_ori     = 6'h0d;
  localparam logic [5:0] primary_lui     = 6'h0f;
  localparam logic [5:0] primary_lw      = 6'h23;
  localparam logic [5:0] primary_sw      = 6'h2b;

  // Function field of SPECIAL instructions, bits 5 to 0.
  localparam logic [5:0] funct_sll  = 6'h00;
  localparam logic [5:0] funct_jr   = 6'h08;
  localparam logic [5:0] funct_addu = 6'h21;
  localparam logic [5:0] funct_subu = 6'h23;
  localparam logic [5:0] funct_and  = 6'h24;
  localparam logic [5:0] funct_or   = 6'h25;
  localparam logic [5:0] funct_xor  = 6'h26;
  localparam logic [5:0] funct_slt  = 6'h2a;

endpackage
